/* id_stage.f */
+incdir+rtl
rtl/id_pkg.sv
rtl/id_ctrl_if.sv
rtl/id_decoder.sv
rtl/id_operand_mux.sv
rtl/id_register_file.sv
rtl/id_multicycle_ctrl.sv
rtl/id_stage.sv
sim/id_stage_asserts.sv
sim/tb_id_stage.sv

/* Makefile */
# Verilator build for the decode stage

VERILATOR ?= verilator
FILELIST  ?= id_stage.f
TB_TOP    ?= tb_id_stage
RTL_TOP   ?= id_stage
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* sim/tb_id_stage.sv */
// Decode stage testbench
`include "id_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
  import id_pkg::*;

  // RV32I major opcodes
  localparam logic [6:0] RV_LOAD   = 7'h03;
  localparam logic [6:0] RV_OP_IMM = 7'h13;
  localparam logic [6:0] RV_AUIPC  = 7'h17;
  localparam logic [6:0] RV_OP     = 7'h33;
  localparam logic [6:0] RV_LUI    = 7'h37;
  localparam int         WAIT_LIMIT = 50;

  logic                clk;
  logic                rst_n;
  logic                instr_valid;
  logic [`ID_XLEN-1:0] instr;
  logic [`ID_XLEN-1:0] pc_id;
  logic                branch_decision;
  logic                ex_ready;
  logic [`ID_XLEN-1:0] ex_wdata;
  logic [`ID_XLEN-1:0] lsu_wdata;
  logic                id_ready;
  logic                illegal_insn;
  alu_op_e             alu_operator;
  logic [`ID_XLEN-1:0] operand_a;
  logic [`ID_XLEN-1:0] operand_b;
  logic                data_req;
  logic                data_we;
  logic [`ID_XLEN-1:0] data_wdata;
  logic                branch_in_ex;
  logic                pc_set;

  // Expected architectural state
  logic [`ID_XLEN-1:0] model_regs [32];
  int                  errors = 0;
  int                  tests_failed = 0;
  int                  assert_fails;

  id_stage id_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_valid_i     (instr_valid),
    .instr_i           (instr),
    .pc_id_i           (pc_id),
    .branch_decision_i (branch_decision),
    .ex_ready_i        (ex_ready),
    .ex_wdata_i        (ex_wdata),
    .lsu_wdata_i       (lsu_wdata),
    .id_ready_o        (id_ready),
    .illegal_insn_o    (illegal_insn),
    .alu_operator_o    (alu_operator),
    .alu_operand_a_o   (operand_a),
    .alu_operand_b_o   (operand_b),
    .data_req_o        (data_req),
    .data_we_o         (data_we),
    .data_wdata_o      (data_wdata),
    .branch_in_ex_o    (branch_in_ex),
    .pc_set_o          (pc_set)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Instruction encoders
  //////////////////////////////
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, RV_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // Always SW
  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  //////////////////////////////
  // Checks and sequencing
  //////////////////////////////
  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start);
    if (errors != start)
      tests_failed++;
    $display("%-16s %s (%0d errors)", name, (errors == start) ? "ok" : "bad", errors - start);
  endtask

  // Drive point is 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Apply an instruction, then settle to the sample point
  task automatic drive_instr(input logic [31:0] word, input logic [31:0] exw,
                             input logic [31:0] lsuw);
    instr       = word;
    instr_valid = 1'b1;
    ex_wdata    = exw;
    lsu_wdata   = lsuw;
    #5;
  endtask

  task automatic finish_single();
    check_flag("id_ready_o", id_ready, 1'b1);
    check_flag("pc_set_o", pc_set, 1'b0);
    next_cycle();
    instr_valid = 1'b0;
  endtask

  // Stall for delay cycles, then release with ex_ready_i and count PC-set pulses
  task automatic finish_multi(input int delay, input logic exp_req, output int pulses);
    int n;
    pulses = int'(pc_set);
    check_flag("id_ready_o", id_ready, 1'b0);
    for (n = 0; n < delay; n++)
    begin
      next_cycle();
      #5;
      pulses += int'(pc_set);
      check_flag("id_ready_o", id_ready, 1'b0);
      check_flag("data_req_o", data_req, exp_req);
    end
    next_cycle();
    ex_ready = 1'b1;
    for (n = 0; n < WAIT_LIMIT; n++)
    begin
      #5;
      pulses += int'(pc_set);
      if (id_ready)
        break;
      next_cycle();
    end
    if (n == WAIT_LIMIT)
      abort_run("timeout, id_ready_o stayed low with ex_ready_i high");
    else
    begin
      next_cycle();
      ex_ready    = 1'b0;
      instr_valid = 1'b0;
    end
  endtask

  // ADDI rd, x0, 0 with the result forced through ex_wdata_i
  task automatic write_reg(input logic [4:0] rd, input logic [31:0] value);
    drive_instr(enc_i(12'h000, 5'd0, 3'd0, rd, RV_OP_IMM), value, 32'h0);
    finish_single();
    if (rd != 5'd0)
      model_regs[rd] = value;
  endtask

  // SW exposes rs2 on data_wdata_o
  task automatic read_reg(input logic [4:0] r);
    int pulses;
    drive_instr(enc_s(12'h000, r, 5'd0), 32'h0, 32'h0);
    check_value($sformatf("data_wdata_o (x%0d)", r), data_wdata, model_regs[r]);
    finish_multi(0, 1'b1, pulses);
  endtask

  task automatic check_all_regs();
    for (int r = 0; r < 32; r++)
      read_reg(5'(r));
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic test_addi_store();
    int start;
    start = errors;
    // addi x5, x0, -123
    drive_instr(enc_i(12'hf85, 5'd0, 3'd0, 5'd5, RV_OP_IMM), 32'hffff_ff85, 32'h0);
    check_value("alu_operand_a_o", operand_a, 32'h0);
    check_value("alu_operand_b_o", operand_b, 32'hffff_ff85);
    check_value("alu_operator_o", 32'(alu_operator), 32'(ALU_ADD));
    check_flag("illegal_insn_o", illegal_insn, 1'b0);
    finish_single();
    model_regs[5] = 32'hffff_ff85;
    read_reg(5'd5);
    report_test("addi_store", start);
  endtask

  task automatic test_rtype();
    int         start;
    logic [2:0] f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [6:0] f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20,
                             7'h00, 7'h00};
    alu_op_e    ops [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                             ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
    logic [31:0] res;
    start = errors;
    write_reg(5'd1, $urandom);
    write_reg(5'd2, $urandom);
    for (int i = 0; i < 10; i++)
    begin
      res = $urandom;
      drive_instr(enc_r(f7s[i], 5'd2, 5'd1, f3s[i], 5'(i + 16)), res, 32'h0);
      check_value("alu_operand_a_o", operand_a, model_regs[1]);
      check_value("alu_operand_b_o", operand_b, model_regs[2]);
      check_value("alu_operator_o", 32'(alu_operator), 32'(ops[i]));
      finish_single();
      model_regs[i + 16] = res;
    end
    // add x0, x1, x2 must not stick
    drive_instr(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0), 32'hdead_beef, 32'h0);
    finish_single();
    read_reg(5'd0);
    read_reg(5'd16);
    read_reg(5'd25);
    report_test("rtype", start);
  endtask

  task automatic test_load();
    int          start;
    int          pulses;
    logic [31:0] ld_data;
    start   = errors;
    ld_data = $urandom;
    // lw x10, 8(x1)
    drive_instr(enc_i(12'h008, 5'd1, 3'b010, 5'd10, RV_LOAD), model_regs[1] + 8, ld_data);
    check_flag("data_req_o", data_req, 1'b1);
    check_flag("data_we_o", data_we, 1'b0);
    check_value("alu_operand_a_o", operand_a, model_regs[1]);
    check_value("alu_operand_b_o", operand_b, 32'h8);
    finish_multi(int'($urandom % 5) + 1, 1'b1, pulses);
    model_regs[10] = ld_data;
    read_reg(5'd10);
    // sw x10, 4(x1) with data on both write-back buses
    drive_instr(enc_s(12'h004, 5'd10, 5'd1), 32'h1111_1111, 32'h2222_2222);
    finish_multi(int'($urandom % 3), 1'b1, pulses);
    check_all_regs();
    report_test("load", start);
  endtask

  task automatic test_immediates();
    int start;
    int pulses;
    start = errors;
    pc_id = 32'h1000_0040;
    drive_instr(enc_u(20'habcde, 5'd11, RV_LUI), 32'habcd_e000, 32'h0);
    check_value("alu_operand_a_o", operand_a, 32'h0);
    check_value("alu_operand_b_o", operand_b, 32'habcd_e000);
    finish_single();
    model_regs[11] = 32'habcd_e000;
    drive_instr(enc_u(20'h80001, 5'd12, RV_AUIPC), 32'h9000_1040, 32'h0);
    check_value("alu_operand_a_o", operand_a, pc_id);
    check_value("alu_operand_b_o", operand_b, 32'h8000_1000);
    finish_single();
    model_regs[12] = 32'h9000_1040;
    // sw x2, -20(x1)
    drive_instr(enc_s(12'hfec, 5'd2, 5'd1), 32'h0, 32'h0);
    check_value("alu_operand_b_o", operand_b, 32'hffff_ffec);
    check_flag("data_we_o", data_we, 1'b1);
    finish_multi(1, 1'b1, pulses);
    read_reg(5'd11);
    read_reg(5'd12);
    report_test("immediates", start);
  endtask

  task automatic test_branches();
    int start;
    int pulses;
    start = errors;
    // Untaken beq
    branch_decision = 1'b0;
    drive_instr(enc_b(13'h010, 5'd2, 5'd1, 3'b000), 32'h0, 32'h0);
    check_flag("branch_in_ex_o", branch_in_ex, 1'b1);
    finish_single();
    // Taken bne
    branch_decision = 1'b1;
    drive_instr(enc_b(13'h1f0, 5'd2, 5'd1, 3'b001), 32'h0, 32'h0);
    check_flag("branch_in_ex_o", branch_in_ex, 1'b1);
    finish_multi(2, 1'b0, pulses);
    branch_decision = 1'b0;
    check_value("pc_set_o pulses (branch)", 32'(pulses), 32'd1);
    // jal x13, +256
    pc_id = 32'h0000_2000;
    drive_instr(enc_j(21'h000100, 5'd13), 32'h0000_2004, 32'h0);
    check_value("alu_operand_a_o", operand_a, 32'h0000_2000);
    check_value("alu_operand_b_o", operand_b, 32'd4);
    finish_multi(1, 1'b0, pulses);
    check_value("pc_set_o pulses (jal)", 32'(pulses), 32'd1);
    model_regs[13] = 32'h0000_2004;
    read_reg(5'd13);
    report_test("branches", start);
  endtask

  task automatic test_illegal();
    int start;
    start = errors;
    // Unknown opcode with rd = x7
    drive_instr({20'h12345, 5'd7, 7'h7f}, 32'h5555_aaaa, 32'h0);
    check_flag("illegal_insn_o", illegal_insn, 1'b1);
    finish_single();
    // OP with funct7 0x01
    drive_instr(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd8), 32'h6666_7777, 32'h0);
    check_flag("illegal_insn_o", illegal_insn, 1'b1);
    finish_single();
    check_all_regs();
    report_test("illegal", start);
  endtask

  // Run limit independent of the per-wait timeouts
  initial
  begin
    #200us;
    abort_run("global time limit reached");
  end

  initial
  begin
    void'($urandom(32'h9494));
    rst_n           = 1'b0;
    instr_valid     = 1'b0;
    instr           = 32'h0000_0013;
    pc_id           = 32'h0;
    branch_decision = 1'b0;
    ex_ready        = 1'b0;
    ex_wdata        = 32'h0;
    lsu_wdata       = 32'h0;
    for (int r = 0; r < 32; r++)
      model_regs[r] = 32'h0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_addi_store();
    test_rtype();
    test_load();
    test_immediates();
    test_branches();
    test_illegal();

    assert_fails = id_stage_i.multicycle_ctrl_i.mc_asserts_i.fail_count;
    $display("Summary: 6 tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_failed, errors, assert_fails);
    if ((errors == 0) && (tests_failed == 0) && (assert_fails == 0))
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/id_stage_asserts.sv */
// Multicycle controller assertions
`timescale 1ns/1ps
`default_nettype none

module id_stage_asserts (
  input logic clk,
  input logic rst_n,
  input logic id_ready_i,
  input logic pc_set_i,
  input logic data_req_i,
  input logic branch_i
);

  // Read by the testbench summary
  int fail_count = 0;

  //////////////////////////////
  // Controller properties
  //////////////////////////////
  // Stall output always resolved once out of reset
  ready_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(id_ready_i))
    else
    begin
      $error("id_ready_o is unknown");
      fail_count = fail_count + 1;
    end

  // PC redirect is a single-cycle pulse
  pc_set_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |=> !pc_set_i)
    else
    begin
      $error("pc_set_o high for two cycles in a row");
      fail_count = fail_count + 1;
    end

  // A memory access is never a branch
  req_not_branch: assert property (@(posedge clk) disable iff (!rst_n)
    !(data_req_i && branch_i))
    else
    begin
      $error("data_req and branch both high");
      fail_count = fail_count + 1;
    end

endmodule

bind id_multicycle_ctrl id_stage_asserts mc_asserts_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .id_ready_i (id_ready_o),
  .pc_set_i   (pc_set_o),
  .data_req_i (ctrl.data_req),
  .branch_i   (ctrl.branch)
);

`default_nettype wire

/* rtl/id_stage.sv */
// Instruction decode stage
`include "id_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  logic                clk,
  input  logic                rst_n,
  // From fetch
  input  logic                instr_valid_i,
  input  logic [`ID_XLEN-1:0] instr_i,
  input  logic [`ID_XLEN-1:0] pc_id_i,
  // From EX and LSU
  input  logic                branch_decision_i,
  input  logic                ex_ready_i,
  input  logic [`ID_XLEN-1:0] ex_wdata_i,
  input  logic [`ID_XLEN-1:0] lsu_wdata_i,
  // Stall and status
  output logic                id_ready_o,
  output logic                illegal_insn_o,
  // To EX
  output id_pkg::alu_op_e     alu_operator_o,
  output logic [`ID_XLEN-1:0] alu_operand_a_o,
  output logic [`ID_XLEN-1:0] alu_operand_b_o,
  // To LSU
  output logic                data_req_o,
  output logic                data_we_o,
  output logic [`ID_XLEN-1:0] data_wdata_o,
  // Flow control
  output logic                branch_in_ex_o,
  output logic                pc_set_o
);

  logic [`ID_XLEN-1:0] rs1_rdata;
  logic [`ID_XLEN-1:0] rs2_rdata;
  logic [`ID_XLEN-1:0] rf_wdata;
  logic                rf_we;

  id_ctrl_if ctrl_if ();

  //////////////////////////////
  // Decode and operands
  //////////////////////////////
  id_decoder decoder_i (
    .instr_i        (instr_i),
    .ctrl           (ctrl_if.dec),
    .illegal_insn_o (illegal_insn_o)
  );

  id_operand_mux operand_mux_i (
    .instr_i     (instr_i),
    .pc_i        (pc_id_i),
    .rs1_rdata_i (rs1_rdata),
    .rs2_rdata_i (rs2_rdata),
    .ctrl        (ctrl_if.opnd),
    .operand_a_o (alu_operand_a_o),
    .operand_b_o (alu_operand_b_o)
  );

  //////////////////////////////
  // Registers and write-back
  //////////////////////////////
  // rs1, rs2 and rd fields feed the ports directly
  id_register_file register_file_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (instr_i[19:15]),
    .raddr_b_i (instr_i[24:20]),
    .rdata_a_o (rs1_rdata),
    .rdata_b_o (rs2_rdata),
    .waddr_i   (instr_i[11:7]),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  id_multicycle_ctrl multicycle_ctrl_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .ctrl              (ctrl_if.ctl),
    .instr_valid_i     (instr_valid_i),
    .branch_decision_i (branch_decision_i),
    .ex_ready_i        (ex_ready_i),
    .ex_wdata_i        (ex_wdata_i),
    .lsu_wdata_i       (lsu_wdata_i),
    .id_ready_o        (id_ready_o),
    .pc_set_o          (pc_set_o),
    .rf_we_o           (rf_we),
    .rf_wdata_o        (rf_wdata)
  );

  // Outputs to EX and LSU
  assign alu_operator_o = ctrl_if.alu_operator;
  assign data_req_o     = ctrl_if.data_req;
  assign data_we_o      = ctrl_if.data_we;
  assign data_wdata_o   = rs2_rdata;
  assign branch_in_ex_o = ctrl_if.branch;

endmodule

`default_nettype wire

/* rtl/id_multicycle_ctrl.sv */
// Multicycle write-back controller
`include "id_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module id_multicycle_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  id_ctrl_if.ctl              ctrl,
  input  logic                instr_valid_i,
  input  logic                branch_decision_i,
  input  logic                ex_ready_i,
  input  logic [`ID_XLEN-1:0] ex_wdata_i,
  input  logic [`ID_XLEN-1:0] lsu_wdata_i,
  output logic                id_ready_o,
  output logic                pc_set_o,
  output logic                rf_we_o,
  output logic [`ID_XLEN-1:0] rf_wdata_o
);
  import id_pkg::*;

  id_state_e state_q;
  id_state_e state_d;
  logic      branch_q;
  logic      taken_branch;
  logic      multicycle;
  logic      stall;
  wb_sel_e   wb_sel;

  assign taken_branch = ctrl.branch & branch_decision_i;
  // Loads, stores, jumps and taken branches need a second phase
  assign multicycle   = instr_valid_i & (ctrl.data_req | ctrl.jump | taken_branch);

  //////////////////////////////
  // State and branch flag
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= ST_IDLE;
      branch_q <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      // Set only on entry to WAIT, so pc_set is a single pulse
      branch_q <= (state_q == ST_IDLE) & instr_valid_i & taken_branch;
    end
  end

  always_comb
  begin
    state_d  = state_q;
    stall    = 1'b0;
    rf_we_o  = 1'b0;
    pc_set_o = 1'b0;
    wb_sel   = WB_EX;

    case (state_q)
      ST_IDLE:
      begin
        stall    = multicycle;
        // Jump target known at decode
        pc_set_o = instr_valid_i & ctrl.jump;
        // Single-cycle write-back straight from EX
        rf_we_o  = instr_valid_i & ctrl.regfile_we & ~multicycle;
        if (multicycle)
          state_d = ST_WAIT;
      end
      default:
      begin
        // Branch target redirect one cycle after decode
        pc_set_o = branch_q;
        stall    = ~ex_ready_i;
        wb_sel   = ctrl.data_req ? WB_LSU : WB_EX;
        if (ex_ready_i)
        begin
          rf_we_o = instr_valid_i & ctrl.regfile_we;
          state_d = ST_IDLE;
        end
      end
    endcase
  end

  assign id_ready_o = ~stall;
  assign rf_wdata_o = (wb_sel == WB_LSU) ? lsu_wdata_i : ex_wdata_i;

endmodule

`default_nettype wire

/* rtl/id_register_file.sv */
// Integer register file
`include "id_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module id_register_file (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`ID_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`ID_REG_ADDR_W-1:0] raddr_b_i,
  output logic [`ID_XLEN-1:0]       rdata_a_o,
  output logic [`ID_XLEN-1:0]       rdata_b_o,
  input  logic [`ID_REG_ADDR_W-1:0] waddr_i,
  input  logic [`ID_XLEN-1:0]       wdata_i,
  input  logic                      we_i
);

  logic [`ID_XLEN-1:0] regs_q [`ID_NUM_REGS];

  // Single write port, x0 never written
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `ID_NUM_REGS; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && (waddr_i != '0))
    begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads
  // x0 holds its reset value, so it always reads zero
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* rtl/id_operand_mux.sv */
// Immediate extraction and operand select
`include "id_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module id_operand_mux (
  input  logic [`ID_XLEN-1:0] instr_i,
  input  logic [`ID_XLEN-1:0] pc_i,
  input  logic [`ID_XLEN-1:0] rs1_rdata_i,
  input  logic [`ID_XLEN-1:0] rs2_rdata_i,
  id_ctrl_if.opnd             ctrl,
  output logic [`ID_XLEN-1:0] operand_a_o,
  output logic [`ID_XLEN-1:0] operand_b_o
);
  import id_pkg::*;

  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm_sb;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_uj;
  logic [`ID_XLEN-1:0] imm_b;

  //////////////////////////////
  // Immediates
  //////////////////////////////
  // All sign extended from bit 31
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
  assign imm_u  = {instr_i[31:12], 12'b0};
  assign imm_uj = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

  always_comb
  begin
    case (ctrl.imm_b_sel)
      IMM_B_S:      imm_b = imm_s;
      IMM_B_U:      imm_b = imm_u;
      IMM_B_SB:     imm_b = imm_sb;
      IMM_B_UJ:     imm_b = imm_uj;
      IMM_B_PCINCR: imm_b = `ID_XLEN'(`ID_PC_INCR);
      default:      imm_b = imm_i;
    endcase
  end

  //////////////////////////////
  // Operands
  //////////////////////////////
  // U format has no rs1, so a register select there gives zero (LUI)
  assign operand_a_o = (ctrl.op_a_sel == OP_A_PC)  ? pc_i :
                       (ctrl.imm_b_sel == IMM_B_U) ? '0   : rs1_rdata_i;

  assign operand_b_o = (ctrl.op_b_sel == OP_B_IMM) ? imm_b : rs2_rdata_i;

endmodule

`default_nettype wire

/* rtl/id_decoder.sv */
// RV32I instruction decoder
`include "id_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
  input  logic [`ID_XLEN-1:0] instr_i,
  id_ctrl_if.dec              ctrl,
  output logic                illegal_insn_o
);
  import id_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Shared arithmetic decode for OP and OP-IMM
  // alt picks SUB or SRA
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  //////////////////////////////
  // Main decode
  //////////////////////////////
  always_comb
  begin
    // Defaults describe a plain register-register op with no side effects
    ctrl.alu_operator = ALU_ADD;
    ctrl.op_a_sel     = OP_A_REG;
    ctrl.op_b_sel     = OP_B_REG;
    ctrl.imm_b_sel    = IMM_B_I;
    ctrl.regfile_we   = 1'b0;
    ctrl.data_req     = 1'b0;
    ctrl.data_we      = 1'b0;
    ctrl.branch       = 1'b0;
    ctrl.jump         = 1'b0;
    illegal_insn_o    = 1'b0;

    case (instr_i[6:0])
      OPC_LUI:
      begin
        // Register select with U immediate means zero on operand A
        ctrl.op_b_sel   = OP_B_IMM;
        ctrl.imm_b_sel  = IMM_B_U;
        ctrl.regfile_we = 1'b1;
      end
      OPC_AUIPC:
      begin
        ctrl.op_a_sel   = OP_A_PC;
        ctrl.op_b_sel   = OP_B_IMM;
        ctrl.imm_b_sel  = IMM_B_U;
        ctrl.regfile_we = 1'b1;
      end
      OPC_JAL:
      begin
        // Link value PC + 4 computed by the ALU
        ctrl.op_a_sel   = OP_A_PC;
        ctrl.op_b_sel   = OP_B_IMM;
        ctrl.imm_b_sel  = IMM_B_PCINCR;
        ctrl.regfile_we = 1'b1;
        ctrl.jump       = 1'b1;
      end
      OPC_BRANCH:
      begin
        ctrl.imm_b_sel = IMM_B_SB;
        ctrl.branch    = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_operator = ALU_EQ;
          3'b001:  ctrl.alu_operator = ALU_NE;
          3'b100:  ctrl.alu_operator = ALU_LT;
          3'b101:  ctrl.alu_operator = ALU_GE;
          3'b110:  ctrl.alu_operator = ALU_LTU;
          3'b111:  ctrl.alu_operator = ALU_GEU;
          default:
          begin
            ctrl.branch    = 1'b0;
            illegal_insn_o = 1'b1;
          end
        endcase
      end
      OPC_LOAD:
      begin
        // Address is rs1 + I immediate
        ctrl.op_b_sel   = OP_B_IMM;
        ctrl.regfile_we = 1'b1;
        ctrl.data_req   = 1'b1;
      end
      OPC_STORE:
      begin
        ctrl.op_b_sel  = OP_B_IMM;
        ctrl.imm_b_sel = IMM_B_S;
        ctrl.data_req  = 1'b1;
        ctrl.data_we   = 1'b1;
      end
      OPC_OP_IMM:
      begin
        // No SUB form, bit 30 only matters for right shifts
        ctrl.op_b_sel     = OP_B_IMM;
        ctrl.regfile_we   = 1'b1;
        ctrl.alu_operator = arith_op(funct3, (funct3 == 3'b101) && instr_i[30]);
      end
      OPC_OP:
      begin
        ctrl.alu_operator = arith_op(funct3, instr_i[30]);
        ctrl.regfile_we   = 1'b1;
        if ((funct7 != 7'h00) && (funct7 != 7'h20))
        begin
          ctrl.regfile_we = 1'b0;
          illegal_insn_o  = 1'b1;
        end
      end
      default:
      begin
        // Unknown opcode, all side effects stay cleared
        illegal_insn_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/id_ctrl_if.sv */
// Decoded control bundle
`timescale 1ns/1ps
`default_nettype none

interface id_ctrl_if;
  import id_pkg::*;

  // ALU and operand control
  alu_op_e    alu_operator;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;
  // Write-back, memory and flow control
  logic       regfile_we;
  logic       data_req;
  logic       data_we;
  logic       branch;
  logic       jump;

  modport dec (output alu_operator, op_a_sel, op_b_sel, imm_b_sel,
               output regfile_we, data_req, data_we, branch, jump);
  modport opnd (input op_a_sel, op_b_sel, imm_b_sel);
  modport ctl (input regfile_we, data_req, branch, jump);
endinterface

`default_nettype wire

/* rtl/id_pkg.sv */
// Decode stage types
`default_nettype none

package id_pkg;

  // Major opcodes in scope
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JAL    = 7'h6f
  } opcode_e;

  // ALU operators, arithmetic first, then compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand selects
  typedef enum logic {OP_A_REG, OP_A_PC} op_a_sel_e;
  typedef enum logic {OP_B_REG, OP_B_IMM} op_b_sel_e;

  // Immediate select for operand B
  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_U, IMM_B_SB, IMM_B_UJ, IMM_B_PCINCR
  } imm_b_sel_e;

  // Write-back source and controller state
  typedef enum logic {WB_EX, WB_LSU} wb_sel_e;
  typedef enum logic {ST_IDLE, ST_WAIT} id_state_e;

endpackage

`default_nettype wire

/* rtl/id_defines.svh */
// Decode stage widths and sizes
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH
`default_nettype none

// Data path width
`define ID_XLEN       32
// Register address width
`define ID_REG_ADDR_W 5
// Number of architectural registers
`define ID_NUM_REGS   32
// Link and PC increment, no compressed support
`define ID_PC_INCR    4

`default_nettype wire
`endif
